// File: branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import mips_isa_pkg::*;
    import idu_ctrl_pkg::*;
(
    input  alu_op_e alu_op_i,
    input  word_t   inst_i,
    input  word_t   pc_i,
    input  word_t   rs_data_i,
    input  word_t   rt_data_i,
    output jump_t   jump_o
);

    i_fmt_t i_f;
    j_fmt_t j_f;
    word_t  pc_plus4;
    word_t  br_target;
    word_t  jmp_target;
    logic   rs_neg;
    logic   rs_zero;
    logic   cond;
    word_t  tgt;

    assign i_f = i_fmt_t'(inst_i);
    assign j_f = j_fmt_t'(inst_i);

    assign pc_plus4   = pc_i + word_t'(4);
    assign br_target  = pc_plus4 + word_t'($signed({i_f.imm, 2'b00}));
    assign jmp_target = {pc_plus4[31:28], j_f.index, 2'b00};  // stays in 256MB region

    assign rs_neg  = rs_data_i[31];
    assign rs_zero = (rs_data_i == '0);

    always_comb begin
        cond = 1'b0;
        tgt  = br_target;
        case (alu_op_i)
            ALU_BEQ:    cond = (rs_data_i == rt_data_i);
            ALU_BNE:    cond = (rs_data_i != rt_data_i);
            ALU_BLEZ:   cond = rs_neg | rs_zero;
            ALU_BGTZ:   cond = ~rs_neg & ~rs_zero;
            ALU_BLTZ:   cond = rs_neg;
            ALU_BGEZAL: cond = ~rs_neg;
            ALU_J, ALU_JAL: begin
                cond = 1'b1;
                tgt  = jmp_target;
            end
            ALU_JR, ALU_JALR: begin
                cond = 1'b1;
                tgt  = rs_data_i;
            end
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        jump_o.taken  = cond;
        jump_o.target = cond ? tgt : '0;
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import mips_isa_pkg::*;
    import idu_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   valid_i,
    input  logic   stall_i,
    input  word_t  inst_i,
    input  word_t  pc_i,
    input  wb_t    wb_i,
    output logic   valid_o,
    output id_ex_t id_ex_o,
    output jump_t  jump_o
);

    r_fmt_t    r_f;
    word_t     rs_data;
    word_t     rt_data;
    word_t     opnd_a;
    word_t     opnd_b;
    dec_ctrl_t ctrl;
    jump_t     jump_d;
    id_ex_t    id_ex_d;

    assign r_f = r_fmt_t'(inst_i);

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .raddr_a_i (r_f.rs),
        .raddr_b_i (r_f.rt),
        .wb_i      (wb_i),
        .rdata_a_o (rs_data),
        .rdata_b_o (rt_data)
    );

    inst_decoder u_inst_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    operand_mux u_operand_mux (
        .op1_sel_i (ctrl.op1_sel),
        .op2_sel_i (ctrl.op2_sel),
        .inst_i    (inst_i),
        .pc_i      (pc_i),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .opnd_a_o  (opnd_a),
        .opnd_b_o  (opnd_b)
    );

    branch_unit u_branch_unit (
        .alu_op_i  (ctrl.alu_op),
        .inst_i    (inst_i),
        .pc_i      (pc_i),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .jump_o    (jump_d)
    );

    always_comb begin
        id_ex_d.alu_op     = ctrl.alu_op;
        id_ex_d.opnd_a     = opnd_a;
        id_ex_d.opnd_b     = opnd_b;
        id_ex_d.store_data = rt_data;  // sw payload
        id_ex_d.mem_we     = ctrl.mem_we;
        id_ex_d.mem_re     = ctrl.mem_re;
        id_ex_d.wb_en      = ctrl.wb_en;
        id_ex_d.wb_addr    = ctrl.wb_addr;
        id_ex_d.illegal    = ctrl.illegal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
            id_ex_o <= '0;
            jump_o  <= '0;
        end else if (!stall_i) begin  // hold everything on stall
            valid_o       <= valid_i;
            id_ex_o       <= id_ex_d;
            jump_o.taken  <= valid_i & jump_d.taken;  // bubbles never redirect
            jump_o.target <= jump_d.target;
        end
    end

endmodule

`default_nettype wire

// File: idu_ctrl_pkg.sv
`default_nettype none

package idu_ctrl_pkg;
    import mips_isa_pkg::*;

    typedef enum logic [4:0] {
        ALU_NOP    = 5'd0,
        ALU_ADD    = 5'd1,
        ALU_ADDU   = 5'd2,
        ALU_SUB    = 5'd3,
        ALU_SUBU   = 5'd4,
        ALU_AND    = 5'd5,
        ALU_OR     = 5'd6,
        ALU_XOR    = 5'd7,
        ALU_SLT    = 5'd8,
        ALU_SLTU   = 5'd9,
        ALU_SLL    = 5'd10,
        ALU_SRL    = 5'd11,
        ALU_SRA    = 5'd12,
        ALU_LUI    = 5'd13,
        ALU_LW     = 5'd14,
        ALU_SW     = 5'd15,
        ALU_BEQ    = 5'd16,
        ALU_BNE    = 5'd17,
        ALU_BLEZ   = 5'd18,
        ALU_BGTZ   = 5'd19,
        ALU_BLTZ   = 5'd20,
        ALU_BGEZAL = 5'd21,
        ALU_J      = 5'd22,
        ALU_JAL    = 5'd23,
        ALU_JR     = 5'd24,
        ALU_JALR   = 5'd25
    } alu_op_e;

    typedef enum logic [2:0] {
        OP1_ZERO = 3'd0,
        OP1_RS   = 3'd1,
        OP1_SA   = 3'd2,
        OP1_LUI  = 3'd3,
        OP1_PC   = 3'd4
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_ZERO = 3'd0,
        OP2_RT   = 3'd1,
        OP2_IMS  = 3'd2,  // sign-extended imm
        OP2_IMZ  = 3'd3,  // zero-extended imm
        OP2_FOUR = 3'd4
    } op2_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        logic      mem_we;
        logic      mem_re;
        logic      wb_en;
        reg_addr_t wb_addr;
        logic      illegal;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     opnd_a;
        word_t     opnd_b;
        word_t     store_data;
        logic      mem_we;
        logic      mem_re;
        logic      wb_en;
        reg_addr_t wb_addr;
        logic      illegal;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } jump_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: idu_settings.svh
`ifndef IDU_SETTINGS_SVH
`define IDU_SETTINGS_SVH

// datapath and address width
`define IDU_XLEN 32

// architectural registers, r0 included
`define IDU_NREGS 32

// link destination of jal and bgezal
`define IDU_LINK_REG 31

`endif

// File: inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "idu_settings.svh"

module inst_decoder
    import mips_isa_pkg::*;
    import idu_ctrl_pkg::*;
(
    input  word_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    localparam reg_addr_t LINK_REG = reg_addr_t'(`IDU_LINK_REG);

    r_fmt_t  r_f;
    alu_op_e r_op;

    function automatic dec_ctrl_t make_ctrl(alu_op_e op, op1_sel_e s1, op2_sel_e s2,
                                            logic wb, reg_addr_t dst);
        dec_ctrl_t c;
        c         = '0;
        c.alu_op  = op;
        c.op1_sel = s1;
        c.op2_sel = s2;
        c.wb_en   = wb;
        c.wb_addr = wb ? dst : '0;
        return c;
    endfunction

    assign r_f = r_fmt_t'(inst_i);

    always_comb begin
        case (r_f.funct)
            F_ADD:   r_op = ALU_ADD;
            F_ADDU:  r_op = ALU_ADDU;
            F_SUB:   r_op = ALU_SUB;
            F_SUBU:  r_op = ALU_SUBU;
            F_AND:   r_op = ALU_AND;
            F_OR:    r_op = ALU_OR;
            F_XOR:   r_op = ALU_XOR;
            F_SLT:   r_op = ALU_SLT;
            F_SLL:   r_op = ALU_SLL;
            F_SRL:   r_op = ALU_SRL;
            F_SRA:   r_op = ALU_SRA;
            default: r_op = ALU_NOP;
        endcase
    end

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.illegal = 1'b1;  // cleared by any legal match
        case (r_f.op)
            OP_SPECIAL: begin
                case (r_f.funct)
                    F_SLL, F_SRL, F_SRA: begin
                        if (r_f.rs == '0) begin
                            ctrl_o = make_ctrl(r_op, OP1_SA, OP2_RT, 1'b1, r_f.rd);
                        end
                    end
                    F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_SLT: begin
                        if (r_f.shamt == '0) begin
                            ctrl_o = make_ctrl(r_op, OP1_RS, OP2_RT, 1'b1, r_f.rd);
                        end
                    end
                    F_JR: begin
                        if (r_f.rt == '0 && r_f.rd == '0 && r_f.shamt == '0) begin
                            ctrl_o = make_ctrl(ALU_JR, OP1_ZERO, OP2_ZERO, 1'b0, '0);
                        end
                    end
                    F_JALR: begin
                        if (r_f.rt == '0 && r_f.shamt == '0) begin
                            ctrl_o = make_ctrl(ALU_JALR, OP1_PC, OP2_FOUR, 1'b1, r_f.rd);
                        end
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                case (regimm_e'(r_f.rt))
                    RI_BLTZ:   ctrl_o = make_ctrl(ALU_BLTZ, OP1_ZERO, OP2_ZERO, 1'b0, '0);
                    RI_BGEZAL: ctrl_o = make_ctrl(ALU_BGEZAL, OP1_PC, OP2_FOUR, 1'b1, LINK_REG);
                    default: ;
                endcase
            end
            OP_ADDI:  ctrl_o = make_ctrl(ALU_ADD, OP1_RS, OP2_IMS, 1'b1, r_f.rt);
            OP_ADDIU: ctrl_o = make_ctrl(ALU_ADDU, OP1_RS, OP2_IMS, 1'b1, r_f.rt);
            OP_SLTI:  ctrl_o = make_ctrl(ALU_SLT, OP1_RS, OP2_IMS, 1'b1, r_f.rt);
            OP_SLTIU: ctrl_o = make_ctrl(ALU_SLTU, OP1_RS, OP2_IMS, 1'b1, r_f.rt);
            OP_ANDI:  ctrl_o = make_ctrl(ALU_AND, OP1_RS, OP2_IMZ, 1'b1, r_f.rt);
            OP_ORI:   ctrl_o = make_ctrl(ALU_OR, OP1_RS, OP2_IMZ, 1'b1, r_f.rt);
            OP_XORI:  ctrl_o = make_ctrl(ALU_XOR, OP1_RS, OP2_IMZ, 1'b1, r_f.rt);
            OP_LUI: begin
                if (r_f.rs == '0) begin
                    ctrl_o = make_ctrl(ALU_LUI, OP1_LUI, OP2_ZERO, 1'b1, r_f.rt);
                end
            end
            OP_LW: begin
                ctrl_o        = make_ctrl(ALU_LW, OP1_RS, OP2_IMS, 1'b1, r_f.rt);
                ctrl_o.mem_re = 1'b1;
            end
            OP_SW: begin
                ctrl_o        = make_ctrl(ALU_SW, OP1_RS, OP2_IMS, 1'b0, '0);
                ctrl_o.mem_we = 1'b1;
            end
            OP_BEQ: ctrl_o = make_ctrl(ALU_BEQ, OP1_ZERO, OP2_ZERO, 1'b0, '0);
            OP_BNE: ctrl_o = make_ctrl(ALU_BNE, OP1_ZERO, OP2_ZERO, 1'b0, '0);
            OP_BLEZ: begin
                if (r_f.rt == '0) begin
                    ctrl_o = make_ctrl(ALU_BLEZ, OP1_ZERO, OP2_ZERO, 1'b0, '0);
                end
            end
            OP_BGTZ: begin
                if (r_f.rt == '0) begin
                    ctrl_o = make_ctrl(ALU_BGTZ, OP1_ZERO, OP2_ZERO, 1'b0, '0);
                end
            end
            OP_J:   ctrl_o = make_ctrl(ALU_J, OP1_ZERO, OP2_ZERO, 1'b0, '0);
            OP_JAL: ctrl_o = make_ctrl(ALU_JAL, OP1_PC, OP2_FOUR, 1'b1, LINK_REG);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
mips_isa_pkg.sv
idu_ctrl_pkg.sv
inst_decoder.sv
operand_mux.sv
branch_unit.sv
reg_file.sv
decode_stage.sv
tb_decode_stage.sv

// File: mips_isa_pkg.sv
`default_nettype none

`include "idu_settings.svh"

package mips_isa_pkg;

    typedef logic [`IDU_XLEN-1:0] word_t;
    typedef logic [4:0]           reg_addr_t;
    typedef logic [15:0]          imm16_t;
    typedef logic [4:0]           shamt_t;
    typedef logic [25:0]          jindex_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_JR   = 6'b001000,
        F_JALR = 6'b001001,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_SLT  = 6'b101010
    } funct_e;

    // rt field codes under OP_REGIMM
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

    typedef struct packed {
        opcode_e   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        funct_e    funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e   op;
        reg_addr_t rs;
        reg_addr_t rt;
        imm16_t    imm;  // also branch offset
    } i_fmt_t;

    typedef struct packed {
        opcode_e op;
        jindex_t index;
    } j_fmt_t;

endpackage

`default_nettype wire

// File: operand_mux.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mux
    import mips_isa_pkg::*;
    import idu_ctrl_pkg::*;
(
    input  op1_sel_e op1_sel_i,
    input  op2_sel_e op2_sel_i,
    input  word_t    inst_i,
    input  word_t    pc_i,
    input  word_t    rs_data_i,
    input  word_t    rt_data_i,
    output word_t    opnd_a_o,
    output word_t    opnd_b_o
);

    r_fmt_t r_f;
    i_fmt_t i_f;
    word_t  sa_z;
    word_t  imm_s;
    word_t  imm_z;
    word_t  imm_hi;

    assign r_f = r_fmt_t'(inst_i);
    assign i_f = i_fmt_t'(inst_i);

    assign sa_z   = word_t'(r_f.shamt);
    assign imm_s  = word_t'($signed(i_f.imm));
    assign imm_z  = word_t'(i_f.imm);
    assign imm_hi = word_t'({i_f.imm, 16'h0000});  // lui places imm in upper half

    always_comb begin
        case (op1_sel_i)
            OP1_RS:  opnd_a_o = rs_data_i;
            OP1_SA:  opnd_a_o = sa_z;
            OP1_LUI: opnd_a_o = imm_hi;
            OP1_PC:  opnd_a_o = pc_i;  // link value base
            default: opnd_a_o = '0;
        endcase
    end

    always_comb begin
        case (op2_sel_i)
            OP2_RT:   opnd_b_o = rt_data_i;
            OP2_IMS:  opnd_b_o = imm_s;
            OP2_IMZ:  opnd_b_o = imm_z;
            OP2_FOUR: opnd_b_o = word_t'(4);
            default:  opnd_b_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "idu_settings.svh"

module reg_file
    import mips_isa_pkg::*;
    import idu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    input  wb_t       wb_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o
);

    word_t regs [`IDU_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IDU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en && wb_i.addr != '0) begin  // r0 is hardwired
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // no bypass, a same-cycle write is seen next cycle
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_decode_stage -f list.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi

// File: tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "idu_settings.svh"

module tb_decode_stage
    import mips_isa_pkg::*;
    import idu_ctrl_pkg::*;
();

    localparam reg_addr_t LINK = reg_addr_t'(`IDU_LINK_REG);
    localparam int MAX_CYCLES = 1000;  // tests take about 450 cycles

    logic   clk;
    logic   rst;
    logic   valid_i;
    logic   stall_i;
    word_t  inst_i;
    word_t  pc_i;
    wb_t    wb_i;
    logic   valid_o;
    id_ex_t id_ex_o;
    jump_t  jump_o;

    word_t  shadow [`IDU_NREGS];
    logic   exp_valid;
    id_ex_t exp_idex;
    jump_t  exp_jump;
    id_ex_t pred_idex;
    jump_t  pred_jump;
    logic   armed = 1'b0;
    int     cycles = 0;
    int     err_cnt = 0;
    int     test_cnt = 0;

    decode_stage dut0 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .stall_i (stall_i),
        .inst_i  (inst_i),
        .pc_i    (pc_i),
        .wb_i    (wb_i),
        .valid_o (valid_o),
        .id_ex_o (id_ex_o),
        .jump_o  (jump_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic flag_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    function automatic alu_op_e funct_to_op(input logic [5:0] fn);
        case (fn)
            6'h00:   return ALU_SLL;
            6'h02:   return ALU_SRL;
            6'h03:   return ALU_SRA;
            6'h20:   return ALU_ADD;
            6'h21:   return ALU_ADDU;
            6'h22:   return ALU_SUB;
            6'h23:   return ALU_SUBU;
            6'h24:   return ALU_AND;
            6'h25:   return ALU_OR;
            6'h26:   return ALU_XOR;
            6'h2a:   return ALU_SLT;
            default: return ALU_NOP;
        endcase
    endfunction

    task automatic set_ops(inout id_ex_t e, input alu_op_e op, input word_t a, input word_t b,
                           input logic wb, input reg_addr_t dst);
        e.alu_op  = op;
        e.opnd_a  = a;
        e.opnd_b  = b;
        e.wb_en   = wb;
        e.wb_addr = wb ? dst : 5'd0;
        e.illegal = 1'b0;
    endtask

    // expected stage outputs for one accepted instruction
    task automatic predict(input logic v, input word_t inst, input word_t pc,
                           output id_ex_t e, output jump_t jmp);
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sh;
        word_t      a;
        word_t      b;
        word_t      sx;
        word_t      p4;
        word_t      btgt;
        logic       cond;
        word_t      tgt;
        op   = inst[31:26];
        fn   = inst[5:0];
        rs   = inst[25:21];
        rt   = inst[20:16];
        rd   = inst[15:11];
        sh   = inst[10:6];
        a    = shadow[rs];
        b    = shadow[rt];
        sx   = {{16{inst[15]}}, inst[15:0]};
        p4   = pc + 32'd4;
        btgt = p4 + {sx[29:0], 2'b00};
        cond = 1'b0;
        tgt  = btgt;
        e    = '0;
        e.illegal    = 1'b1;
        e.store_data = b;
        case (op)
            6'h00: begin
                if (fn inside {6'h00, 6'h02, 6'h03} && rs == 5'd0) begin
                    set_ops(e, funct_to_op(fn), {27'd0, sh}, b, 1'b1, rd);
                end else if (fn inside {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a}
                             && sh == 5'd0) begin
                    set_ops(e, funct_to_op(fn), a, b, 1'b1, rd);
                end else if (fn == 6'h08 && rt == 5'd0 && rd == 5'd0 && sh == 5'd0) begin
                    set_ops(e, ALU_JR, '0, '0, 1'b0, '0);
                    cond = 1'b1;
                    tgt  = a;
                end else if (fn == 6'h09 && rt == 5'd0 && sh == 5'd0) begin
                    set_ops(e, ALU_JALR, pc, 32'd4, 1'b1, rd);
                    cond = 1'b1;
                    tgt  = a;
                end
            end
            6'h01: begin
                if (rt == 5'h00) begin
                    set_ops(e, ALU_BLTZ, '0, '0, 1'b0, '0);
                    cond = a[31];
                end else if (rt == 5'h11) begin
                    set_ops(e, ALU_BGEZAL, pc, 32'd4, 1'b1, LINK);
                    cond = !a[31];
                end
            end
            6'h02, 6'h03: begin
                if (op == 6'h02) set_ops(e, ALU_J, '0, '0, 1'b0, '0);
                else set_ops(e, ALU_JAL, pc, 32'd4, 1'b1, LINK);
                cond = 1'b1;
                tgt  = {p4[31:28], inst[25:0], 2'b00};
            end
            6'h04: begin
                set_ops(e, ALU_BEQ, '0, '0, 1'b0, '0);
                cond = (a == b);
            end
            6'h05: begin
                set_ops(e, ALU_BNE, '0, '0, 1'b0, '0);
                cond = (a != b);
            end
            6'h06: begin
                if (rt == 5'd0) begin
                    set_ops(e, ALU_BLEZ, '0, '0, 1'b0, '0);
                    cond = a[31] || a == 32'd0;
                end
            end
            6'h07: begin
                if (rt == 5'd0) begin
                    set_ops(e, ALU_BGTZ, '0, '0, 1'b0, '0);
                    cond = !a[31] && a != 32'd0;
                end
            end
            6'h08: set_ops(e, ALU_ADD, a, sx, 1'b1, rt);
            6'h09: set_ops(e, ALU_ADDU, a, sx, 1'b1, rt);
            6'h0a: set_ops(e, ALU_SLT, a, sx, 1'b1, rt);
            6'h0b: set_ops(e, ALU_SLTU, a, sx, 1'b1, rt);
            6'h0c: set_ops(e, ALU_AND, a, {16'd0, inst[15:0]}, 1'b1, rt);
            6'h0d: set_ops(e, ALU_OR, a, {16'd0, inst[15:0]}, 1'b1, rt);
            6'h0e: set_ops(e, ALU_XOR, a, {16'd0, inst[15:0]}, 1'b1, rt);
            6'h0f: begin
                if (rs == 5'd0) set_ops(e, ALU_LUI, {inst[15:0], 16'd0}, '0, 1'b1, rt);
            end
            6'h23: begin
                set_ops(e, ALU_LW, a, sx, 1'b1, rt);
                e.mem_re = 1'b1;
            end
            6'h2b: begin
                set_ops(e, ALU_SW, a, sx, 1'b0, '0);
                e.mem_we = 1'b1;
            end
            default: ;
        endcase
        jmp.taken  = v & cond;
        jmp.target = cond ? tgt : '0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IDU_NREGS; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_i.en && wb_i.addr != 5'd0) begin
            shadow[wb_i.addr] <= wb_i.data;
        end
    end

    // expectation for the next edge
    always @(posedge clk) begin
        armed <= 1'b1;
        if (rst) begin
            exp_valid <= 1'b0;
            exp_idex  <= '0;
            exp_jump  <= '0;
        end else if (!stall_i) begin
            predict(valid_i, inst_i, pc_i, pred_idex, pred_jump);
            exp_valid <= valid_i;
            exp_idex  <= pred_idex;
            exp_jump  <= pred_jump;
        end
    end

    valid_chk: assert property (@(posedge clk) armed |-> valid_o == exp_valid)
        else flag_error($sformatf("valid_o %0b, expected %0b",
                                  $sampled(valid_o), $sampled(exp_valid)));
    idex_chk: assert property (@(posedge clk) armed |-> id_ex_o == exp_idex)
        else flag_error($sformatf("id_ex_o %h, expected %h",
                                  $sampled(id_ex_o), $sampled(exp_idex)));
    jump_chk: assert property (@(posedge clk) armed |-> jump_o == exp_jump)
        else flag_error($sformatf("jump_o %h, expected %h",
                                  $sampled(jump_o), $sampled(exp_jump)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic word_t rand_pc();
        return {30'($urandom), 2'b00};
    endfunction

    function automatic logic is_kept_op(input logic [5:0] op);
        return op <= 6'h0f || op == 6'h23 || op == 6'h2b;
    endfunction

    task automatic drive_inst(input word_t inst, input word_t pc);
        valid_i = 1'b1;
        stall_i = 1'b0;
        inst_i  = inst;
        pc_i    = pc;
        @(negedge clk);
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        valid_i    = 1'b0;
        wb_i.en    = 1'b1;
        wb_i.addr  = addr;
        wb_i.data  = data;
        @(negedge clk);
        wb_i = '0;
    endtask

    task automatic finish_test(input string name, input int start);
        $display("%-10s done, %0d errors", name, err_cnt - start);
        test_cnt++;
    endtask

    initial begin
        int          start;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [5:0]  r_functs [11];
        logic [5:0]  imm_ops [10];
        logic [5:0]  bad_functs [8];
        id_ex_t      held_idex;
        jump_t       held_jump;
        void'($urandom(32'h2a3b));
        r_functs   = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a,
                       6'h00, 6'h02, 6'h03};
        imm_ops    = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                       6'h23, 6'h2b};
        bad_functs = '{6'h18, 6'h19, 6'h1a, 6'h1b, 6'h10, 6'h12, 6'h0c, 6'h0d};
        rst     = 1'b1;
        valid_i = 1'b1;
        stall_i = 1'b0;
        inst_i  = {6'h02, 26'h0abcdef};  // a jump must not leak through reset
        pc_i    = 32'h0000_1000;
        wb_i    = '0;

        start = err_cnt;
        repeat (16) begin
            @(negedge clk);
            assert (!valid_o && !jump_o.taken) else flag_error("outputs active during reset");
        end
        rst = 1'b0;
        valid_i = 1'b0;
        @(negedge clk);  // first edge out of reset, jump still on the bus
        assert (!valid_o && !jump_o.taken) else flag_error("outputs active after reset");
        finish_test("reset", start);

        start = err_cnt;
        for (int i = 0; i < 32; i++) begin
            write_reg(5'(i), $urandom);  // r0 write must be ignored
        end
        for (int f = 0; f < 11; f++) begin
            for (int k = 0; k < 8; k++) begin
                rs = (k == 0) ? 5'd0 : 5'($urandom);
                rt = (k == 1) ? 5'd0 : 5'($urandom);
                if (f >= 8) drive_inst({6'h00, 5'd0, rt, 5'($urandom), 5'($urandom), r_functs[f]},
                                       rand_pc());
                else drive_inst({6'h00, rs, rt, 5'($urandom), 5'd0, r_functs[f]}, rand_pc());
            end
        end
        finish_test("r-type", start);

        start = err_cnt;
        for (int f = 0; f < 10; f++) begin
            for (int k = 0; k < 6; k++) begin
                rs = (imm_ops[f] == 6'h0f) ? 5'd0 : 5'($urandom);
                drive_inst({imm_ops[f], rs, 5'($urandom), 16'($urandom)}, rand_pc());
            end
        end
        finish_test("immediate", start);

        start = err_cnt;
        write_reg(5'd1, 32'hffff_ffff);
        write_reg(5'd2, 32'd1);
        write_reg(5'd3, 32'd0);
        write_reg(5'd4, 32'h8000_0000);
        write_reg(5'd5, shadow[6]);  // equal pair for beq and bne
        for (int r = 0; r < 8; r++) begin
            drive_inst({6'h06, 5'(r), 5'd0, 16'($urandom)}, rand_pc());
            drive_inst({6'h07, 5'(r), 5'd0, 16'($urandom)}, rand_pc());
            drive_inst({6'h01, 5'(r), 5'h00, 16'($urandom)}, rand_pc());
            drive_inst({6'h01, 5'(r), 5'h11, 16'($urandom)}, rand_pc());
            drive_inst({6'h04, 5'(r), (r < 4) ? 5'(r) : 5'($urandom), 16'($urandom)}, rand_pc());
            drive_inst({6'h05, 5'd5, (r < 4) ? 5'd6 : 5'($urandom), 16'($urandom)}, rand_pc());
            drive_inst({6'h02, 26'($urandom)}, rand_pc());
            drive_inst({6'h03, 26'($urandom)}, rand_pc());
            drive_inst({6'h00, 5'($urandom), 15'd0, 6'h08}, rand_pc());
            drive_inst({6'h00, 5'($urandom), 5'd0, 5'($urandom), 5'd0, 6'h09}, rand_pc());
        end
        finish_test("branch", start);

        start = err_cnt;
        for (int k = 0; k < 40; k++) begin
            case (k % 5)
                0: begin
                    op = 6'($urandom);
                    while (is_kept_op(op)) op = 6'($urandom);
                    drive_inst({op, 26'($urandom)}, rand_pc());
                end
                1: begin
                    fn = bad_functs[k % 8];
                    drive_inst({6'h00, 20'($urandom), fn}, rand_pc());
                end
                2: drive_inst({6'h01, 5'($urandom), 5'h01, 16'($urandom)}, rand_pc());
                3: drive_inst({6'h00, 15'($urandom), 5'd3, 6'h20}, rand_pc());
                default: drive_inst({6'h06, 5'($urandom), 5'd7, 16'($urandom)}, rand_pc());
            endcase
            assert (id_ex_o.illegal && !id_ex_o.wb_en && !id_ex_o.mem_we && !id_ex_o.mem_re
                    && !jump_o.taken)
                else flag_error($sformatf("encoding %h not treated as illegal", inst_i));
        end
        finish_test("illegal", start);

        start = err_cnt;
        drive_inst({6'h08, 5'd1, 5'd2, 16'($urandom)}, rand_pc());
        held_idex = id_ex_o;
        held_jump = jump_o;
        stall_i = 1'b1;
        inst_i  = {6'h03, 26'($urandom)};  // jal waits upstream
        pc_i    = rand_pc();
        repeat (5) begin
            @(negedge clk);
            assert (valid_o && id_ex_o == held_idex && jump_o == held_jump)
                else flag_error("outputs changed while stalled");
        end
        stall_i = 1'b0;
        @(negedge clk);
        assert (valid_o && id_ex_o.alu_op == ALU_JAL && jump_o.taken)
            else flag_error("held instruction did not appear one cycle after the stall ended");
        valid_i = 1'b0;
        @(negedge clk);
        assert (!valid_o && !jump_o.taken) else flag_error("bubble shown as a valid instruction");
        for (int k = 0; k < 60; k++) begin
            if (!stall_i) begin
                valid_i = 1'($urandom);
                inst_i  = {3'b001, 3'($urandom), 26'($urandom)};
                pc_i    = rand_pc();
            end
            stall_i = ($urandom % 4 == 0);
            @(negedge clk);
        end
        stall_i = 1'b0;
        valid_i = 1'b0;
        repeat (2) @(negedge clk);
        finish_test("stall", start);

        $display("%0d tests, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
